//--- Makefile
# Verilator build and run of the mode-control core testbench

VERILATOR ?= verilator
TOP       ?= board_mode_ctrl_tb
FILELIST  ?= board_mode_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test failed, no result line"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/board_mode_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_mode_macros.svh"

module board_mode_ctrl_tb;

	localparam int hold          = 8;
	localparam int press_cycles  = 20;
	localparam int bounce_cycles = 5;  // shorter than hold
	localparam int settle_cycles = 20; // release filtered before the next key
	localparam int route_cycles  = 50;
	localparam int wait_limit    = 64;
	localparam int burst_w = 2 + 2 * `BURST_LEN_W + 2 * `BURST_ADDR_W + `BURST_DATA_W;
	localparam int seg_w   = `SEG_SEL_W + `SEG_DATA_W;

	localparam logic [`SEG_SEL_W-1:0]  rtc_sel_val     = 6'h15;
	localparam logic [`SEG_DATA_W-1:0] rtc_data_val    = 8'hc3;
	localparam logic [`SEG_SEL_W-1:0]  eeprom_sel_val  = 6'h2a;
	localparam logic [`SEG_DATA_W-1:0] eeprom_data_val = 8'h5e;
	localparam logic [`SEG_SEL_W-1:0]  sd_sel_val      = 6'h07;
	localparam logic [`SEG_DATA_W-1:0] sd_data_val     = 8'h91;

	logic clk;
	logic rst_n;
	logic key2;
	logic key3;
	logic key4;
	logic [`SEG_SEL_W-1:0]    rtc_seg_sel;
	logic [`SEG_DATA_W-1:0]   rtc_seg_data;
	logic [`SEG_SEL_W-1:0]    eeprom_seg_sel;
	logic [`SEG_DATA_W-1:0]   eeprom_seg_data;
	logic [`SEG_SEL_W-1:0]    sd_seg_sel;
	logic [`SEG_DATA_W-1:0]   sd_seg_data;
	logic                     sd_rd_req;
	logic                     sd_wr_req;
	logic [`BURST_LEN_W-1:0]  sd_rd_len;
	logic [`BURST_LEN_W-1:0]  sd_wr_len;
	logic [`BURST_ADDR_W-1:0] sd_rd_addr;
	logic [`BURST_ADDR_W-1:0] sd_wr_addr;
	logic [`BURST_DATA_W-1:0] sd_wr_data;
	logic                     cam_rd_req;
	logic                     cam_wr_req;
	logic [`BURST_LEN_W-1:0]  cam_rd_len;
	logic [`BURST_LEN_W-1:0]  cam_wr_len;
	logic [`BURST_ADDR_W-1:0] cam_rd_addr;
	logic [`BURST_ADDR_W-1:0] cam_wr_addr;
	logic [`BURST_DATA_W-1:0] cam_wr_data;
	logic [`SEG_SEL_W-1:0]    seg_sel;
	logic [`SEG_DATA_W-1:0]   seg_data;
	logic                     sd_rst_n;
	logic                     cam_rst_n;
	logic                     buzzer_rst_n;
	logic                     mem_rst_n;
	logic                     eeprom_key;
	logic                     sd_key;
	logic                     mem_rd_req;
	logic                     mem_wr_req;
	logic [`BURST_LEN_W-1:0]  mem_rd_len;
	logic [`BURST_LEN_W-1:0]  mem_wr_len;
	logic [`BURST_ADDR_W-1:0] mem_rd_addr;
	logic [`BURST_ADDR_W-1:0] mem_wr_addr;
	logic [`BURST_DATA_W-1:0] mem_wr_data;

	int    errors = 0;
	int    checks = 0;
	int    timeouts = 0;
	int    seed;
	int    eeprom_pulses = 0;
	int    sd_pulses = 0;
	int    fd;
	int    fields;
	int    steps;
	int    step_key;
	int    exp_sd;
	int    exp_cam;
	int    exp_buz;
	int    exp_code;
	int    prev_sd;
	string line;
	string step_name;

	board_mode_ctrl #(.hold_cycles(hold)) DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// outputs only move on the rising edge
	always @(negedge clk)
	begin
		if (eeprom_key)
			eeprom_pulses++;
		if (sd_key)
			sd_pulses++;
	end

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("Error: %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	function automatic logic [seg_w-1:0] seg_source(input int code);
		case (code)
			1: return {eeprom_sel_val, eeprom_data_val};
			2: return {sd_sel_val, sd_data_val};
			default: return {rtc_sel_val, rtc_data_val};
		endcase
	endfunction

	// read and write never requested together
	function automatic logic [burst_w-1:0] random_request();
		logic [95:0] r;
		r = {$random(seed), $random(seed), $random(seed)};
		return {r[95], r[94] && !r[95], r[burst_w-3:0]};
	endfunction

	task automatic drive_clients(input logic sd_owns, output logic [burst_w-1:0] owner_fields);
		logic [burst_w-1:0] sd_f;
		logic [burst_w-1:0] cam_f;
		sd_f  = random_request();
		cam_f = random_request();
		{sd_rd_req, sd_wr_req, sd_rd_len, sd_wr_len, sd_rd_addr, sd_wr_addr, sd_wr_data} = sd_f;
		{cam_rd_req, cam_wr_req, cam_rd_len, cam_wr_len, cam_rd_addr, cam_wr_addr,
			cam_wr_data} = cam_f;
		owner_fields = sd_owns ? sd_f : cam_f; // owner of the expected mode
	endtask

	task automatic check_routing(input int cycles, input logic sd_owns);
		logic [burst_w-1:0] expected;
		logic [burst_w-1:0] actual;
		drive_clients(sd_owns, expected);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			actual = {mem_rd_req, mem_wr_req, mem_rd_len, mem_wr_len, mem_rd_addr,
				mem_wr_addr, mem_wr_data};
			check_value(sd_owns ? "sd_route" : "cam_route", expected, actual);
			drive_clients(sd_owns, expected);
		end
	endtask

	task automatic set_key(input int k, input logic level);
		case (k)
			2: key2 = level;
			3: key3 = level;
			default: key4 = level;
		endcase
	endtask

	task automatic hold_key(input int k, input int cycles);
		set_key(k, 1'b0); // active low
		repeat (cycles) @(negedge clk);
		set_key(k, 1'b1);
		repeat (settle_cycles) @(negedge clk);
	endtask

	task automatic measure_mem_reset(input string name, input logic expect_pulse,
		input int cycles);
		int n;
		int low;
		n = 0;
		low = 0;
		if (expect_pulse)
		begin
			while (mem_rst_n && n < wait_limit)
			begin
				@(negedge clk);
				n++;
			end
			if (mem_rst_n)
			begin
				timeouts++;
				$display("timeout: %s, the sdram reset never went low", name);
			end
			else
			begin
				while (!mem_rst_n && low < wait_limit)
				begin
					low++;
					@(negedge clk);
				end
				check_value({name, " mem_rst_n low cycles"}, 16, low);
			end
		end
		else
		begin
			repeat (cycles + settle_cycles)
			begin
				@(negedge clk);
				if (!mem_rst_n)
					low++;
			end
			check_value({name, " mem_rst_n low cycles"}, 0, low);
		end
	endtask

	task automatic wait_levels(input string name, input logic e_sd, input logic e_cam,
		input logic e_buz, input logic [seg_w-1:0] e_seg);
		int n;
		n = 0;
		while ({sd_rst_n, cam_rst_n, buzzer_rst_n, seg_sel, seg_data} !==
			{e_sd, e_cam, e_buz, e_seg} && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if ({sd_rst_n, cam_rst_n, buzzer_rst_n, seg_sel, seg_data} !==
			{e_sd, e_cam, e_buz, e_seg})
		begin
			timeouts++;
			$display("timeout: %s, reset levels and display never settled", name);
		end
		check_value({name, " sd_rst_n"}, e_sd, sd_rst_n);
		check_value({name, " cam_rst_n"}, e_cam, cam_rst_n);
		check_value({name, " buzzer_rst_n"}, e_buz, buzzer_rst_n);
		check_value({name, " display"}, e_seg, {seg_sel, seg_data});
	endtask

	// one key action, pressed only if held past the debounce time
	task automatic press_step(input string name, input int k, input int cycles,
		input logic pressed, input logic e_sd, input logic e_cam, input logic e_buz,
		input int code, input logic expect_mem);
		int ee0;
		int sd0;
		ee0 = eeprom_pulses;
		sd0 = sd_pulses;
		fork
			hold_key(k, cycles);
			measure_mem_reset(name, expect_mem, cycles);
		join
		wait_levels(name, e_sd, e_cam, e_buz, seg_source(code));
		check_value({name, " eeprom_key pulses"}, (pressed && k == 3) ? 1 : 0,
			eeprom_pulses - ee0);
		check_value({name, " sd_key pulses"}, (pressed && k == 4) ? 1 : 0, sd_pulses - sd0);
	endtask

	initial
	begin
		seed = 32'hfe42812c;
		rst_n = 1'b0;
		key2 = 1'b1;
		key3 = 1'b1;
		key4 = 1'b1;
		rtc_seg_sel = rtc_sel_val;
		rtc_seg_data = rtc_data_val;
		eeprom_seg_sel = eeprom_sel_val;
		eeprom_seg_data = eeprom_data_val;
		sd_seg_sel = sd_sel_val;
		sd_seg_data = sd_data_val;
		{sd_rd_req, sd_wr_req, sd_rd_len, sd_wr_len, sd_rd_addr, sd_wr_addr, sd_wr_data} = '0;
		{cam_rd_req, cam_wr_req, cam_rd_len, cam_wr_len, cam_rd_addr, cam_wr_addr,
			cam_wr_data} = '0;

		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		check_value("reset sd_rst_n", 0, sd_rst_n);
		check_value("reset cam_rst_n", 0, cam_rst_n);
		check_value("reset buzzer_rst_n", 0, buzzer_rst_n);
		@(negedge clk); // idle levels one clock later
		check_value("idle sd_rst_n", 0, sd_rst_n);
		check_value("idle cam_rst_n", 1, cam_rst_n);
		check_value("idle buzzer_rst_n", 0, buzzer_rst_n);
		check_value("idle mem_rst_n", 1, mem_rst_n);
		check_value("idle display", seg_source(0), {seg_sel, seg_data});
		check_routing(route_cycles, 1'b0);

		prev_sd = 0;
		steps = 0;
		fd = $fopen("bench/board_mode_golden.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the golden file bench/board_mode_golden.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#")
				begin
					fields = $sscanf(line, "%s %d %d %d %d %d", step_name, step_key,
						exp_sd, exp_cam, exp_buz, exp_code);
					if (fields != 6)
					begin
						errors++;
						$display("golden file line could not be read: %s", line);
					end
					else
					begin
						press_step(step_name, step_key, press_cycles, 1'b1, exp_sd != 0,
							exp_cam != 0, exp_buz != 0, exp_code, exp_sd != prev_sd);
						check_routing(route_cycles, exp_sd != 0);
						prev_sd = exp_sd;
						steps++;
					end
				end
			end
			$fclose(fd);
			if (steps == 0)
			begin
				errors++;
				$display("the golden file held no steps");
			end
		end

		// short bounces leave the last mode alone
		for (int k = 2; k <= 4; k++)
			press_step($sformatf("bounce_key%0d", k), k, bounce_cycles, 1'b0, exp_sd != 0,
				exp_cam != 0, exp_buz != 0, exp_code, 1'b0);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/board_mode_golden.txt
# step name, key pressed (2, 3 or 4), expected sd_rst_n, cam_rst_n, buzzer_rst_n,
# expected display source (0 rtc, 1 eeprom, 2 sd)
led_from_idle      2 0 1 1 0
led_own_key        2 0 1 1 0
eeprom_from_led    3 0 1 0 1
eeprom_own_key     3 0 1 0 1
sd_from_eeprom     4 1 0 0 2
sd_own_key         4 1 0 0 2
led_from_sd        2 0 1 1 0
sd_from_led        4 1 0 0 2
eeprom_from_sd     3 0 1 0 1
led_from_eeprom    2 0 1 1 0
eeprom_again       3 0 1 0 1
sd_again           4 1 0 0 2
sd_own_key_again   4 1 0 0 2
led_again          2 0 1 1 0
led_own_key_again  2 0 1 1 0
sd_last            4 1 0 0 2
eeprom_last        3 0 1 0 1

//--- board_mode_ctrl.f
+incdir+logic
logic/board_mode_pkg.sv
logic/key_debounce.sv
logic/mode_fsm.sv
logic/burst_arbiter.sv
logic/display_select.sv
logic/board_mode_ctrl.sv
bench/board_mode_ctrl_tb.sv

//--- logic/board_mode_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_mode_macros.svh"

// mode-control core of the board
module board_mode_ctrl #(
	parameter int hold_cycles = `DEBOUNCE_CYCLES
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       key2,
	input  wire                       key3,
	input  wire                       key4,
	input  wire [`SEG_SEL_W-1:0]      rtc_seg_sel,
	input  wire [`SEG_DATA_W-1:0]     rtc_seg_data,
	input  wire [`SEG_SEL_W-1:0]      eeprom_seg_sel,
	input  wire [`SEG_DATA_W-1:0]     eeprom_seg_data,
	input  wire [`SEG_SEL_W-1:0]      sd_seg_sel,
	input  wire [`SEG_DATA_W-1:0]     sd_seg_data,
	input  wire                       sd_rd_req,
	input  wire                       sd_wr_req,
	input  wire [`BURST_LEN_W-1:0]    sd_rd_len,
	input  wire [`BURST_LEN_W-1:0]    sd_wr_len,
	input  wire [`BURST_ADDR_W-1:0]   sd_rd_addr,
	input  wire [`BURST_ADDR_W-1:0]   sd_wr_addr,
	input  wire [`BURST_DATA_W-1:0]   sd_wr_data,
	input  wire                       cam_rd_req,
	input  wire                       cam_wr_req,
	input  wire [`BURST_LEN_W-1:0]    cam_rd_len,
	input  wire [`BURST_LEN_W-1:0]    cam_wr_len,
	input  wire [`BURST_ADDR_W-1:0]   cam_rd_addr,
	input  wire [`BURST_ADDR_W-1:0]   cam_wr_addr,
	input  wire [`BURST_DATA_W-1:0]   cam_wr_data,
	output logic [`SEG_SEL_W-1:0]     seg_sel,
	output logic [`SEG_DATA_W-1:0]    seg_data,
	output logic                      sd_rst_n,
	output logic                      cam_rst_n,
	output logic                      buzzer_rst_n,
	output logic                      mem_rst_n,
	output logic                      eeprom_key,
	output logic                      sd_key,
	output logic                      mem_rd_req,
	output logic                      mem_wr_req,
	output logic [`BURST_LEN_W-1:0]   mem_rd_len,
	output logic [`BURST_LEN_W-1:0]   mem_wr_len,
	output logic [`BURST_ADDR_W-1:0]  mem_rd_addr,
	output logic [`BURST_ADDR_W-1:0]  mem_wr_addr,
	output logic [`BURST_DATA_W-1:0]  mem_wr_data
);

	logic                  press2;
	logic                  press3;
	logic                  press4;
	logic                  sd_owner;
	board_mode_pkg::mode_t mode;

	key_debounce #(.hold_cycles(hold_cycles)) u_key2 (
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key2),
		.press (press2)
	);

	key_debounce #(.hold_cycles(hold_cycles)) u_key3 (
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key3),
		.press (press3)
	);

	// sd key filtered on the main clock too
	key_debounce #(.hold_cycles(hold_cycles)) u_key4 (
		.clk   (clk),
		.rst_n (rst_n),
		.key   (key4),
		.press (press4)
	);

	mode_fsm u_mode_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.press2       (press2),
		.press3       (press3),
		.press4       (press4),
		.mode         (mode),
		.sd_owner     (sd_owner),
		.sd_rst_n     (sd_rst_n),
		.cam_rst_n    (cam_rst_n),
		.buzzer_rst_n (buzzer_rst_n),
		.mem_rst_n    (mem_rst_n),
		.eeprom_key   (eeprom_key),
		.sd_key       (sd_key)
	);

	burst_arbiter u_burst_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.sd_owner    (sd_owner),
		.sd_rd_req   (sd_rd_req),
		.sd_wr_req   (sd_wr_req),
		.sd_rd_len   (sd_rd_len),
		.sd_wr_len   (sd_wr_len),
		.sd_rd_addr  (sd_rd_addr),
		.sd_wr_addr  (sd_wr_addr),
		.sd_wr_data  (sd_wr_data),
		.cam_rd_req  (cam_rd_req),
		.cam_wr_req  (cam_wr_req),
		.cam_rd_len  (cam_rd_len),
		.cam_wr_len  (cam_wr_len),
		.cam_rd_addr (cam_rd_addr),
		.cam_wr_addr (cam_wr_addr),
		.cam_wr_data (cam_wr_data),
		.mem_rd_req  (mem_rd_req),
		.mem_wr_req  (mem_wr_req),
		.mem_rd_len  (mem_rd_len),
		.mem_wr_len  (mem_wr_len),
		.mem_rd_addr (mem_rd_addr),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data)
	);

	display_select u_display_select (
		.clk             (clk),
		.rst_n           (rst_n),
		.mode            (mode),
		.rtc_seg_sel     (rtc_seg_sel),
		.rtc_seg_data    (rtc_seg_data),
		.eeprom_seg_sel  (eeprom_seg_sel),
		.eeprom_seg_data (eeprom_seg_data),
		.sd_seg_sel      (sd_seg_sel),
		.sd_seg_data     (sd_seg_data),
		.seg_sel         (seg_sel),
		.seg_data        (seg_data)
	);

endmodule

`default_nettype wire

//--- logic/board_mode_macros.svh
`ifndef BOARD_MODE_MACROS_SVH
`define BOARD_MODE_MACROS_SVH

// seven-segment display
`define SEG_SEL_W 6   // digit select
`define SEG_DATA_W 8  // segments plus dot

// sdram burst port
`define BURST_LEN_W 10
`define BURST_ADDR_W 24
`define BURST_DATA_W 16

// sdram reset pulse counter, all ones ends the pulse
`define MEM_RST_CNT_W 4

// key must read stable this many clocks before it counts
`define DEBOUNCE_CYCLES 1000000

`endif

//--- logic/board_mode_pkg.sv
`default_nettype none

// shared types for the mode-control core
package board_mode_pkg;

	// board operating modes, one per active function
	typedef enum logic [1:0] {
		MODE_IDLE      = 2'd0, // after reset, rtc clock on the display
		MODE_LED_FLASH = 2'd1, // buzzer running
		MODE_EEPROM    = 2'd2, // eeprom test owns the display
		MODE_SD_CARD   = 2'd3  // sd picture client owns the sdram
	} mode_t;

endpackage

`default_nettype wire

//--- logic/burst_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_mode_macros.svh"

// routes the owning client's burst requests onto the shared sdram port
module burst_arbiter (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      sd_owner, // high: sd client, low: camera
	input  wire                      sd_rd_req,
	input  wire                      sd_wr_req,
	input  wire [`BURST_LEN_W-1:0]   sd_rd_len,
	input  wire [`BURST_LEN_W-1:0]   sd_wr_len,
	input  wire [`BURST_ADDR_W-1:0]  sd_rd_addr,
	input  wire [`BURST_ADDR_W-1:0]  sd_wr_addr,
	input  wire [`BURST_DATA_W-1:0]  sd_wr_data,
	input  wire                      cam_rd_req,
	input  wire                      cam_wr_req,
	input  wire [`BURST_LEN_W-1:0]   cam_rd_len,
	input  wire [`BURST_LEN_W-1:0]   cam_wr_len,
	input  wire [`BURST_ADDR_W-1:0]  cam_rd_addr,
	input  wire [`BURST_ADDR_W-1:0]  cam_wr_addr,
	input  wire [`BURST_DATA_W-1:0]  cam_wr_data,
	output logic                     mem_rd_req,
	output logic                     mem_wr_req,
	output logic [`BURST_LEN_W-1:0]  mem_rd_len,
	output logic [`BURST_LEN_W-1:0]  mem_wr_len,
	output logic [`BURST_ADDR_W-1:0] mem_rd_addr,
	output logic [`BURST_ADDR_W-1:0] mem_wr_addr,
	output logic [`BURST_DATA_W-1:0] mem_wr_data
);

	// ownership follows the mode, the clients never run together
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mem_rd_req  <= 1'b0;
			mem_wr_req  <= 1'b0;
			mem_rd_len  <= '0;
			mem_wr_len  <= '0;
			mem_rd_addr <= '0;
			mem_wr_addr <= '0;
			mem_wr_data <= '0;
		end
		else if (sd_owner)
		begin
			mem_rd_req  <= sd_rd_req;
			mem_wr_req  <= sd_wr_req;
			mem_rd_len  <= sd_rd_len;
			mem_wr_len  <= sd_wr_len;
			mem_rd_addr <= sd_rd_addr;
			mem_wr_addr <= sd_wr_addr;
			mem_wr_data <= sd_wr_data;
		end
		else
		begin
			mem_rd_req  <= cam_rd_req;
			mem_wr_req  <= cam_wr_req;
			mem_rd_len  <= cam_rd_len;
			mem_wr_len  <= cam_wr_len;
			mem_rd_addr <= cam_rd_addr;
			mem_wr_addr <= cam_wr_addr;
			mem_wr_data <= cam_wr_data;
		end
	end

	// controller takes one burst direction at a time
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_rd_req && mem_wr_req))
		else $error("burst_arbiter: read and write burst requested together");

endmodule

`default_nettype wire

//--- logic/display_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_mode_macros.svh"

// picks the seven-segment source for the current mode
module display_select (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire board_mode_pkg::mode_t mode,
	input  wire [`SEG_SEL_W-1:0]      rtc_seg_sel,
	input  wire [`SEG_DATA_W-1:0]     rtc_seg_data,
	input  wire [`SEG_SEL_W-1:0]      eeprom_seg_sel,
	input  wire [`SEG_DATA_W-1:0]     eeprom_seg_data,
	input  wire [`SEG_SEL_W-1:0]      sd_seg_sel,
	input  wire [`SEG_DATA_W-1:0]     sd_seg_data,
	output logic [`SEG_SEL_W-1:0]     seg_sel,
	output logic [`SEG_DATA_W-1:0]    seg_data
);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			seg_sel  <= '0; // blank
			seg_data <= '0;
		end
		else
		begin
			case (mode)
				board_mode_pkg::MODE_EEPROM:
				begin
					seg_sel  <= eeprom_seg_sel;
					seg_data <= eeprom_seg_data;
				end
				board_mode_pkg::MODE_SD_CARD:
				begin
					seg_sel  <= sd_seg_sel;
					seg_data <= sd_seg_data;
				end
				default: // idle and led flash show the clock
				begin
					seg_sel  <= rtc_seg_sel;
					seg_data <= rtc_seg_data;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/key_debounce.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_mode_macros.svh"

// one board key: sync, bounce filter, press pulse
module key_debounce #(
	parameter int hold_cycles = `DEBOUNCE_CYCLES
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  key,   // active low
	output logic press  // one cycle per press
);

	localparam int cnt_w = $clog2(hold_cycles + 1);

	logic [1:0]       key_sync;   // two-stage synchronizer
	logic             key_level;  // filtered key level
	logic [cnt_w-1:0] stable_cnt; // clocks the new level has held
	logic             level_done;

	// new level has now held for hold_cycles samples
	assign level_done = (key_sync[1] != key_level) &&
		(stable_cnt == cnt_w'(hold_cycles - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			key_sync <= 2'b11; // released
		else
			key_sync <= {key_sync[0], key};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stable_cnt <= '0;
			key_level  <= 1'b1;
		end
		else if (key_sync[1] == key_level)
			stable_cnt <= '0; // bounce back, start over
		else if (level_done)
		begin
			key_level  <= key_sync[1];
			stable_cnt <= '0;
		end
		else
			stable_cnt <= stable_cnt + 1'b1;
	end

	// falling filtered level only, release is silent
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			press <= 1'b0;
		else
			press <= level_done && !key_sync[1];
	end

	a_press_single: assert property (@(posedge clk) disable iff (!rst_n)
		press |=> !press)
		else $error("key_debounce: press held for two cycles");

endmodule

`default_nettype wire

//--- logic/mode_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "board_mode_macros.svh"

// board mode machine with per-mode client resets and sdram reset pulse
module mode_fsm (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  press2, // led flash key
	input  wire                  press3, // eeprom key
	input  wire                  press4, // sd card key
	output board_mode_pkg::mode_t mode,
	output logic                 sd_owner,
	output logic                 sd_rst_n,
	output logic                 cam_rst_n,
	output logic                 buzzer_rst_n,
	output logic                 mem_rst_n,
	output logic                 eeprom_key,
	output logic                 sd_key
);

	board_mode_pkg::mode_t      next_mode;
	logic                       sd_edge;     // press enters or leaves sd mode
	logic [`MEM_RST_CNT_W-1:0]  mem_rst_cnt;

	// the state register is the mode output itself
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mode <= board_mode_pkg::MODE_IDLE;
		else
			mode <= next_mode;
	end

	// key2 wins over key3 over key4, own key of the current mode ignored
	always_comb
	begin
		next_mode = mode;
		if (press2 && mode != board_mode_pkg::MODE_LED_FLASH)
			next_mode = board_mode_pkg::MODE_LED_FLASH;
		else if (press3 && mode != board_mode_pkg::MODE_EEPROM)
			next_mode = board_mode_pkg::MODE_EEPROM;
		else if (press4 && mode != board_mode_pkg::MODE_SD_CARD)
			next_mode = board_mode_pkg::MODE_SD_CARD;
	end

	assign sd_edge = (mode == board_mode_pkg::MODE_SD_CARD) !=
		(next_mode == board_mode_pkg::MODE_SD_CARD);

	// client reset levels, one cycle behind the mode
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sd_rst_n     <= 1'b0;
			cam_rst_n    <= 1'b0;
			buzzer_rst_n <= 1'b0;
		end
		else
		begin
			sd_rst_n     <= (mode == board_mode_pkg::MODE_SD_CARD);
			cam_rst_n    <= (mode != board_mode_pkg::MODE_SD_CARD);
			buzzer_rst_n <= (mode == board_mode_pkg::MODE_LED_FLASH);
		end
	end

	assign sd_owner = sd_rst_n; // sd client runs only while out of reset

	// sdram controller restarts whenever its owner changes
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_rst_n <= 1'b0;
		else if (sd_edge)
			mem_rst_n <= 1'b0;
		else if (mem_rst_cnt == '1)
			mem_rst_n <= 1'b1; // 16 clocks low
		else if (mode == board_mode_pkg::MODE_IDLE)
			mem_rst_n <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_rst_cnt <= '0;
		else if (mem_rst_n)
			mem_rst_cnt <= '0;
		else
			mem_rst_cnt <= mem_rst_cnt + 1'b1;
	end

	// eeprom test sees its key one clock late
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			eeprom_key <= 1'b0;
		else
			eeprom_key <= press3;
	end

	assign sd_key = press4;

	a_one_client: assert property (@(posedge clk) disable iff (!rst_n)
		!(sd_rst_n && cam_rst_n))
		else $error("mode_fsm: sd and camera clients both out of reset");

	a_mem_rst_len: assert property (@(posedge clk) disable iff (!rst_n)
		!mem_rst_n [*16] |=> mem_rst_n)
		else $error("mode_fsm: sdram reset longer than 16 cycles");

endmodule

`default_nettype wire
